// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_uart_bridge
RTL_TOP    ?= uart_bridge_top
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
RTL_SRCS   ?= hw/uart_bridge_pkg.sv hw/uart_tx_frame.sv hw/uart_rx_frame.sv \
              hw/uart_cmd_engine.sv hw/cmd_dispatch.sv hw/rsp_collect.sv \
              hw/uart_bridge_top.sv
TB_SRCS    ?= tests/uart_slave_model.sv tests/tb_uart_bridge.sv

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

// ==== hw/cmd_dispatch.sv ====
`timescale 1ns/1ns

module cmd_dispatch (
  input  logic                              clk,
  input  logic                              rst_n,
  input  uart_bridge_pkg::cmd_word_u        cmd,
  input  logic [uart_bridge_pkg::CH_W-1:0]  ch,
  input  logic                              cmd_vld,
  output logic                              cmd_rdy,
  input  logic [uart_bridge_pkg::NUM_CH-1:0] busy,
  output logic [uart_bridge_pkg::NUM_CH-1:0] start,
  output uart_bridge_pkg::cmd_word_u        ch_cmd [uart_bridge_pkg::NUM_CH]
);

  logic [uart_bridge_pkg::NUM_CH-1:0] sel;
  logic [uart_bridge_pkg::NUM_CH-1:0] acc_mask;
  logic [uart_bridge_pkg::NUM_CH-1:0] pending;
  logic                               accept;

  assign sel      = {{(uart_bridge_pkg::NUM_CH - 1){1'b0}}, 1'b1} << ch;
  assign cmd_rdy  = !busy[ch] && !pending[ch];
  assign accept   = cmd_vld && cmd_rdy;
  assign acc_mask = accept ? sel : '0;

  // pending bridges the two cycles until the engine reports busy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start   <= '0;
      pending <= '0;
    end else begin
      start   <= acc_mask;
      pending <= (pending & ~busy) | acc_mask;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < uart_bridge_pkg::NUM_CH; i++) begin
      if (acc_mask[i])
        ch_cmd[i] <= cmd;
    end
  end

endmodule

// ==== hw/rsp_collect.sv ====
`timescale 1ns/1ns

module rsp_collect (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [uart_bridge_pkg::NUM_CH-1:0] rsp_vld,
  input  uart_bridge_pkg::rsp_t              rsp [uart_bridge_pkg::NUM_CH],
  output logic [uart_bridge_pkg::NUM_CH-1:0] take,
  output logic                               read_vld,
  output uart_bridge_pkg::rsp_t              read_rsp
);

  uart_bridge_pkg::ch_t ptr;
  uart_bridge_pkg::ch_t gnt_idx;
  uart_bridge_pkg::ch_t idx;
  logic                 gnt_any;

  // search starts one past the last grant
  always_comb begin
    gnt_any = 1'b0;
    gnt_idx = ptr;
    idx     = ptr;
    for (int k = 1; k <= uart_bridge_pkg::NUM_CH; k++) begin
      idx = ptr + uart_bridge_pkg::ch_t'(k);
      if (!gnt_any && rsp_vld[idx]) begin
        gnt_any = 1'b1;
        gnt_idx = idx;
      end
    end
  end

  always_comb begin
    take = '0;
    if (gnt_any)
      take[gnt_idx] = 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr      <= '1;
      read_vld <= 1'b0;
    end else begin
      read_vld <= gnt_any;
      if (gnt_any)
        ptr <= gnt_idx;
    end
  end

  always_ff @(posedge clk) begin
    if (gnt_any)
      read_rsp <= rsp[gnt_idx];
  end

  // a granted response is gone one cycle later
  a_take_drops: assert property (@(posedge clk) disable iff (!rst_n)
    (take != '0) |=> ((rsp_vld & $past(take)) == '0));

endmodule

// ==== hw/uart_bridge_pkg.sv ====
package uart_bridge_pkg;

  localparam int NUM_CH       = 4;
  localparam int CH_W         = 2;
  localparam int CLKS_PER_BIT = 16;
  localparam int FRAME_BITS   = 11;

  // response start bit must show up within this many cycles
  localparam int RX_TIMEOUT = 40 * CLKS_PER_BIT;

  localparam int CLK_CNT_W = $clog2(CLKS_PER_BIT);
  localparam int BIT_CNT_W = $clog2(FRAME_BITS);
  localparam int TMO_W     = $clog2(RX_TIMEOUT);

  // counter end values
  localparam logic [CLK_CNT_W-1:0] BIT_LAST   = CLK_CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CLK_CNT_W-1:0] SAMPLE_PT  = CLK_CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [BIT_CNT_W-1:0] FRAME_LAST = BIT_CNT_W'(FRAME_BITS - 1);
  localparam logic [TMO_W-1:0]     TMO_LAST   = TMO_W'(RX_TIMEOUT - 1);

  typedef logic [CH_W-1:0] ch_t;

  typedef struct packed {
    logic       rd;
    logic [6:0] addr;
    logic [7:0] wdata;
  } cmd_fields_t;

  // byte 1 goes out as the address frame, byte 0 as the data frame
  typedef union packed {
    cmd_fields_t     f;
    logic [1:0][7:0] b;
  } cmd_word_u;

  typedef struct packed {
    ch_t        ch;
    logic       timeout;
    logic       parity_err;
    logic [7:0] data;
  } rsp_t;

endpackage

// ==== hw/uart_bridge_top.sv ====
`timescale 1ns/1ns

module uart_bridge_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  uart_bridge_pkg::cmd_word_u         cmd,
  input  logic [uart_bridge_pkg::CH_W-1:0]   ch,
  input  logic                               cmd_vld,
  output logic                               cmd_rdy,
  output logic [uart_bridge_pkg::NUM_CH-1:0] tx,
  input  logic [uart_bridge_pkg::NUM_CH-1:0] rx,
  output logic                               read_vld,
  output uart_bridge_pkg::rsp_t              read_rsp
);

  logic [uart_bridge_pkg::NUM_CH-1:0] busy;
  logic [uart_bridge_pkg::NUM_CH-1:0] start;
  logic [uart_bridge_pkg::NUM_CH-1:0] rsp_vld;
  logic [uart_bridge_pkg::NUM_CH-1:0] take;
  uart_bridge_pkg::cmd_word_u         ch_cmd [uart_bridge_pkg::NUM_CH];
  uart_bridge_pkg::rsp_t              rsp [uart_bridge_pkg::NUM_CH];

  cmd_dispatch u_dispatch (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .ch      (ch),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .busy    (busy),
    .start   (start),
    .ch_cmd  (ch_cmd)
  );

  for (genvar i = 0; i < uart_bridge_pkg::NUM_CH; i++) begin : g_eng
    uart_cmd_engine u_eng (
      .clk     (clk),
      .rst_n   (rst_n),
      .start   (start[i]),
      .cmd     (ch_cmd[i]),
      .ch_id   (uart_bridge_pkg::ch_t'(i)),
      .busy    (busy[i]),
      .rsp_vld (rsp_vld[i]),
      .rsp     (rsp[i]),
      .take    (take[i]),
      .tx      (tx[i]),
      .rx      (rx[i])
    );
  end

  rsp_collect u_collect (
    .clk      (clk),
    .rst_n    (rst_n),
    .rsp_vld  (rsp_vld),
    .rsp      (rsp),
    .take     (take),
    .read_vld (read_vld),
    .read_rsp (read_rsp)
  );

endmodule

// ==== hw/uart_cmd_engine.sv ====
`timescale 1ns/1ns

module uart_cmd_engine (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            start,
  input  uart_bridge_pkg::cmd_word_u      cmd,
  input  logic [uart_bridge_pkg::CH_W-1:0] ch_id,
  output logic                            busy,
  output logic                            rsp_vld,
  output uart_bridge_pkg::rsp_t           rsp,
  input  logic                            take,
  output logic                            tx,
  input  logic                            rx
);

  typedef enum logic [2:0] {S_IDLE, S_ADDR, S_DATA, S_RXW, S_HOLD} eng_state_t;

  eng_state_t                 state;
  uart_bridge_pkg::cmd_word_u cmd_q;
  logic                       tx_start;
  logic [7:0]                 tx_byte;
  logic                       tx_done;
  logic                       rx_arm;
  logic                       rx_done;
  logic [7:0]                 rx_byte;
  logic                       rx_parity_err;
  logic                       rx_timeout;

  assign busy    = (state != S_IDLE);
  assign rsp_vld = (state == S_HOLD);

  // address byte straight from the dispatcher, data byte from the held copy
  assign tx_start = ((state == S_IDLE) && start) ||
                    ((state == S_ADDR) && tx_done && !cmd_q.f.rd);
  assign tx_byte  = (state == S_IDLE) ? cmd.b[1] : cmd_q.b[0];
  assign rx_arm   = (state == S_ADDR) && tx_done && cmd_q.f.rd;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: if (start) state <= S_ADDR;
        S_ADDR: begin
          if (tx_done)
            state <= cmd_q.f.rd ? S_RXW : S_DATA;
        end
        S_DATA: if (tx_done) state <= S_IDLE;
        S_RXW:  if (rx_done) state <= S_HOLD;
        S_HOLD: if (take) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == S_IDLE) && start)
      cmd_q <= cmd;
    if ((state == S_RXW) && rx_done) begin
      rsp.ch         <= ch_id;
      rsp.timeout    <= rx_timeout;
      rsp.parity_err <= rx_parity_err;
      rsp.data       <= rx_byte;
    end
  end

  uart_tx_frame u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_rx_frame u_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx_arm        (rx_arm),
    .rx            (rx),
    .rx_done       (rx_done),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err),
    .rx_timeout    (rx_timeout)
  );

  a_take_held: assert property (@(posedge clk) disable iff (!rst_n)
    take |-> rsp_vld);

  // dispatcher pending mask must keep a running channel from restarting
  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> !busy);

endmodule

// ==== hw/uart_rx_frame.sv ====
`timescale 1ns/1ns

module uart_rx_frame (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx_arm,
  input  logic       rx,
  output logic       rx_done,
  output logic [7:0] rx_byte,
  output logic       rx_parity_err,
  output logic       rx_timeout
);

  typedef enum logic [1:0] {R_IDLE, R_WAIT, R_RECV} rx_state_t;

  rx_state_t                             state;
  logic                                  rx_meta;
  logic                                  rx_s;
  logic                                  rx_prev;
  logic [uart_bridge_pkg::CLK_CNT_W-1:0] clk_cnt;
  logic [uart_bridge_pkg::BIT_CNT_W-1:0] bit_cnt;
  logic [uart_bridge_pkg::TMO_W-1:0]     tmo_cnt;
  logic [8:0]                            shreg;
  logic                                  fall;
  logic                                  sample;
  logic                                  tmo_hit;
  logic                                  stop_hit;

  assign fall     = rx_prev && !rx_s;
  assign sample   = (state == R_RECV) && (clk_cnt == uart_bridge_pkg::SAMPLE_PT);
  assign stop_hit = sample && (bit_cnt == uart_bridge_pkg::FRAME_LAST);
  assign tmo_hit  = (state == R_WAIT) && !fall && (tmo_cnt == uart_bridge_pkg::TMO_LAST);

  // two-flop sync plus one for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_s    <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_s    <= rx_meta;
      rx_prev <= rx_s;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= R_IDLE;
      clk_cnt <= '0;
      bit_cnt <= '0;
      tmo_cnt <= '0;
      rx_done <= 1'b0;
    end else begin
      rx_done <= tmo_hit || stop_hit;
      case (state)
        R_IDLE: begin
          if (rx_arm) begin
            state   <= R_WAIT;
            tmo_cnt <= '0;
          end
        end
        R_WAIT: begin
          if (fall) begin
            state   <= R_RECV;
            clk_cnt <= '0;
            bit_cnt <= '0;
          end else if (tmo_hit) begin
            state <= R_IDLE;
          end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
          end
        end
        R_RECV: begin
          clk_cnt <= (clk_cnt == uart_bridge_pkg::BIT_LAST) ? '0 : clk_cnt + 1'b1;
          if (stop_hit)
            state <= R_IDLE;
          else if (sample)
            bit_cnt <= bit_cnt + 1'b1;
        end
        default: state <= R_IDLE;
      endcase
    end
  end

  // start bit falls off the end, leaving parity and data
  always_ff @(posedge clk) begin
    if (sample)
      shreg <= {rx_s, shreg[8:1]};
    if (stop_hit) begin
      rx_byte       <= shreg[7:0];
      rx_parity_err <= ~(^shreg) || !rx_s;
      rx_timeout    <= 1'b0;
    end else if (tmo_hit) begin
      rx_byte       <= '0;
      rx_parity_err <= 1'b0;
      rx_timeout    <= 1'b1;
    end
  end

endmodule

// ==== hw/uart_tx_frame.sv ====
`timescale 1ns/1ns

module uart_tx_frame (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       tx_done
);

  logic                                  busy;
  logic [uart_bridge_pkg::CLK_CNT_W-1:0] clk_cnt;
  logic [uart_bridge_pkg::BIT_CNT_W-1:0] bit_cnt;
  logic [9:0]                            shreg;
  logic                                  bit_end;

  assign bit_end = busy && (clk_cnt == uart_bridge_pkg::BIT_LAST);
  assign tx_done = bit_end && (bit_cnt == uart_bridge_pkg::FRAME_LAST);

  // a new start may land in the last stop cycle so frames run back to back
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
      tx      <= 1'b1;
    end else if (tx_start) begin
      busy    <= 1'b1;
      clk_cnt <= '0;
      bit_cnt <= '0;
      tx      <= 1'b0;
    end else if (bit_end) begin
      clk_cnt <= '0;
      tx      <= shreg[0];
      if (bit_cnt == uart_bridge_pkg::FRAME_LAST)
        busy <= 1'b0;
      else
        bit_cnt <= bit_cnt + 1'b1;
    end else if (busy) begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // stop, odd parity, data; ones fill in behind
  always_ff @(posedge clk) begin
    if (tx_start)
      shreg <= {1'b1, ~^tx_byte, tx_byte};
    else if (bit_end)
      shreg <= {1'b1, shreg[9:1]};
  end

  a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !busy || tx_done);

endmodule

// ==== list.f ====
hw/uart_bridge_pkg.sv
hw/uart_tx_frame.sv
hw/uart_rx_frame.sv
hw/uart_cmd_engine.sv
hw/cmd_dispatch.sv
hw/rsp_collect.sv
hw/uart_bridge_top.sv
tests/uart_slave_model.sv
tests/tb_uart_bridge.sv

// ==== tests/tb_uart_bridge.sv ====
`timescale 1ns/1ns

module tb_uart_bridge;

  localparam int NUM_CH     = uart_bridge_pkg::NUM_CH;
  localparam int WAIT_LIMIT = 4000;

  logic                       clk;
  logic                       rst_n;
  uart_bridge_pkg::cmd_word_u cmd;
  uart_bridge_pkg::ch_t       ch;
  logic                       cmd_vld;
  logic                       cmd_rdy;
  logic [NUM_CH-1:0]          tx;
  logic [NUM_CH-1:0]          rx;
  logic                       read_vld;
  uart_bridge_pkg::rsp_t      read_rsp;

  logic [NUM_CH-1:0]          mute;
  logic [NUM_CH-1:0]          corrupt;
  logic [NUM_CH-1:0]          frame_err;
  logic                       chk_idle;

  logic [7:0]                 shadow [NUM_CH][128];
  logic [NUM_CH-1:0][127:0]   written;
  logic [NUM_CH-1:0][7:0]     exp_data;
  logic [NUM_CH-1:0]          exp_tmo;
  logic [NUM_CH-1:0]          exp_perr;
  int                         exp_reads [NUM_CH];
  int                         got_reads [NUM_CH];
  int                         exp_total;
  int                         got_total;
  logic [6:0]                 addr_q [NUM_CH];
  logic [7:0]                 data_q [NUM_CH];

  uart_bridge_top u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .ch       (ch),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx       (tx),
    .rx       (rx),
    .read_vld (read_vld),
    .read_rsp (read_rsp)
  );

  for (genvar i = 0; i < NUM_CH; i++) begin : g_slave
    uart_slave_model u_slave (
      .clk       (clk),
      .rst_n     (rst_n),
      .line_in   (tx[i]),
      .line_out  (rx[i]),
      .mute      (mute[i]),
      .corrupt   (corrupt[i]),
      .frame_err (frame_err[i])
    );
  end

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  always @(posedge clk) begin
    if (read_vld) begin
      got_reads[read_rsp.ch] <= got_reads[read_rsp.ch] + 1;
      got_total              <= got_total + 1;
    end
  end

  a_idle_lines: assert property (@(posedge clk)
    chk_idle |-> (&tx) && cmd_rdy && !read_vld)
    else abort_run($sformatf("[FAIL] %0t: idle state wrong, tx=%b cmd_rdy=%b ch=%0d",
                             $time, $sampled(tx), $sampled(cmd_rdy), $sampled(ch)));

  a_rsp_expected: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> got_reads[read_rsp.ch] < exp_reads[read_rsp.ch])
    else abort_run($sformatf("[FAIL] %0t: response on channel %0d with no read open",
                             $time, $sampled(read_rsp.ch)));

  a_rsp_data: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> read_rsp.data == exp_data[read_rsp.ch])
    else abort_run($sformatf("[FAIL] %0t: channel %0d data %h, expected %h", $time,
                             $sampled(read_rsp.ch), $sampled(read_rsp.data),
                             $sampled(exp_data[read_rsp.ch])));

  a_rsp_flags: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> read_rsp.timeout == exp_tmo[read_rsp.ch] &&
                 read_rsp.parity_err == exp_perr[read_rsp.ch])
    else abort_run($sformatf("[FAIL] %0t: channel %0d flags tmo=%b perr=%b wrong", $time,
                             $sampled(read_rsp.ch), $sampled(read_rsp.timeout),
                             $sampled(read_rsp.parity_err)));

  a_frame_ok: assert property (@(posedge clk) disable iff (!rst_n) frame_err == '0)
    else abort_run($sformatf("[FAIL] %0t: bad parity or stop bit seen by slave, mask %b",
                             $time, $sampled(frame_err)));

  // hold the command until the cycle it is taken
  task automatic send_cmd(input int c, input logic rd, input logic [6:0] a,
                          input logic [7:0] d);
    uart_bridge_pkg::cmd_word_u w;
    int n;
    w.f.rd    = rd;
    w.f.addr  = a;
    w.f.wdata = d;
    n = 0;
    @(posedge clk);
    ch      <= uart_bridge_pkg::ch_t'(c);
    cmd     <= w;
    cmd_vld <= 1'b1;
    do begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT)
        abort_run("command was never accepted by the bridge");
    end while (!cmd_rdy);
    cmd_vld <= 1'b0;
  endtask

  task automatic do_write(input int c, input logic [6:0] a, input logic [7:0] d);
    shadow[c][a]  = d;
    written[c][a] = 1'b1;
    send_cmd(c, 1'b0, a, d);
  endtask

  task automatic do_read(input int c, input logic [6:0] a);
    exp_data[c] = mute[c] ? 8'h00 : shadow[c][a];
    exp_tmo[c]  = mute[c];
    exp_perr[c] = corrupt[c] && !mute[c];
    exp_reads[c]++;
    exp_total++;
    send_cmd(c, 1'b1, a, 8'h00);
  endtask

  task automatic wait_reads();
    int n;
    n = 0;
    while (got_total != exp_total) begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT)
        abort_run("read response did not arrive in time");
    end
  endtask

  task automatic wait_ready(input int c);
    int n;
    n = 0;
    @(posedge clk);
    ch <= uart_bridge_pkg::ch_t'(c);
    do begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT)
        abort_run("cmd_rdy did not come back after the read");
    end while (!cmd_rdy);
  endtask

  task automatic set_faults(input logic [NUM_CH-1:0] m, input logic [NUM_CH-1:0] p);
    @(posedge clk);
    mute    <= m;
    corrupt <= p;
    @(posedge clk);
  endtask

  function automatic logic [6:0] fresh_addr(input int c);
    logic [6:0] a;
    a = 7'($urandom);
    for (int i = 0; i < 128 && written[c][a]; i++)
      a = a + 7'd1;
    return a;
  endfunction

  initial begin
    void'($urandom(39647));
    rst_n    <= 1'b0;
    cmd      <= '0;
    ch       <= '0;
    cmd_vld  <= 1'b0;
    mute     <= '0;
    corrupt  <= '0;
    chk_idle <= 1'b0;
    written = '0;
    for (int c = 0; c < NUM_CH; c++)
      for (int a = 0; a < 128; a++)
        shadow[c][a] = 8'(a) ^ 8'hA5;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // sweep ch while idle
    @(posedge clk);
    chk_idle <= 1'b1;
    for (int c = 0; c < NUM_CH; c++) begin
      ch <= uart_bridge_pkg::ch_t'(c);
      @(posedge clk);
    end
    chk_idle <= 1'b0;

    // write then read back, one channel at a time
    for (int c = 0; c < NUM_CH; c++) begin
      addr_q[c] = 7'($urandom);
      data_q[c] = 8'($urandom);
      do_write(c, addr_q[c], data_q[c]);
      do_read(c, addr_q[c]);
      wait_reads();
    end

    // all channels at once
    for (int c = 0; c < NUM_CH; c++) begin
      addr_q[c] = 7'($urandom);
      data_q[c] = 8'($urandom);
      do_write(c, addr_q[c], data_q[c]);
    end
    for (int c = 0; c < NUM_CH; c++)
      do_read(c, addr_q[c]);
    wait_reads();

    // untouched addresses
    for (int c = 0; c < NUM_CH; c++)
      do_read(c, fresh_addr(c));
    wait_reads();

    set_faults(4'b0100, 4'b0000);
    do_read(2, 7'($urandom));
    wait_reads();
    wait_ready(2);

    set_faults(4'b0000, 4'b0010);
    do_read(1, 7'($urandom));
    wait_reads();
    set_faults(4'b0000, 4'b0000);

    repeat (10) @(posedge clk);
    if (got_total == exp_total) begin
      $display("TEST PASS");
      $finish;
    end else begin
      abort_run("response count does not match the reads issued");
    end
  end

endmodule

// ==== tests/uart_slave_model.sv ====
`timescale 1ns/1ns

module uart_slave_model (
  input  logic clk,
  input  logic rst_n,
  input  logic line_in,
  output logic line_out,
  input  logic mute,
  input  logic corrupt,
  output logic frame_err
);

  localparam int BIT_CLKS = uart_bridge_pkg::CLKS_PER_BIT;

  logic [7:0] mem [128];
  logic [7:0] rx_byte;
  logic       rx_ok;
  logic       wr_next;
  logic [6:0] wr_addr;

  // first low seen is one cycle into the start bit, so land mid-bit from here
  task automatic get_frame(output logic [7:0] data, output logic ok);
    logic [9:0] bits;
    repeat (BIT_CLKS / 2 - 1) @(posedge clk);
    for (int i = 0; i < 10; i++) begin
      repeat (BIT_CLKS) @(posedge clk);
      bits[i] = line_in;
    end
    data = bits[7:0];
    ok   = (^bits[8:0]) && bits[9];
  endtask

  task automatic put_frame(input logic [7:0] data, input logic bad_par);
    logic [10:0] bits;
    bits = {1'b1, (~^data) ^ bad_par, data, 1'b0};
    for (int i = 0; i < 11; i++) begin
      line_out <= bits[i];
      repeat (BIT_CLKS) @(posedge clk);
    end
  endtask

  initial begin
    line_out  <= 1'b1;
    frame_err <= 1'b0;
    wr_next = 1'b0;
    wr_addr = '0;
    // power-up contents tied to every address bit
    for (int i = 0; i < 128; i++)
      mem[i] = 8'(i) ^ 8'hA5;
    forever begin
      @(posedge clk);
      frame_err <= 1'b0;
      if (rst_n && !line_in) begin
        get_frame(rx_byte, rx_ok);
        if (!rx_ok)
          frame_err <= 1'b1;
        if (wr_next) begin
          mem[wr_addr] = rx_byte;
          wr_next      = 1'b0;
        end else if (rx_byte[7]) begin
          // turnaround before the answer
          repeat (3 * BIT_CLKS) @(posedge clk);
          if (!mute)
            put_frame(mem[rx_byte[6:0]], corrupt);
        end else begin
          wr_addr = rx_byte[6:0];
          wr_next = 1'b1;
        end
      end
    end
  end

endmodule
